// File: hw/arb_pkg.sv
package arb_pkg;

  // byte address as seen on the console bus
  localparam int ADDR_W = 24;
  // PSRAM data bus
  localparam int DATA_W = 16;

  // memory cycle FSM
  typedef enum logic [1:0] {
    idle    = 2'd0,
    rd_addr = 2'd1,
    wr_addr = 2'd2,
    done    = 2'd3
  } arb_state_e;

  // owner of the access in flight
  // value doubles as index into grant and done
  typedef enum logic [1:0] {
    src_gsu_rom = 2'd0,
    src_gsu_ram = 2'd1,
    src_mcu     = 2'd2
  } req_src_e;

  // PSRAM cycle length in CLK2 periods, minus one
  localparam int unsigned ROM_CYCLE_LEN_DEF = 6;
  // about 1 ms of CLK2 with no console clock
  localparam int unsigned DEAD_TIMEOUT_DEF = 96000;

endpackage

// File: hw/bus_pkg.sv
package bus_pkg;

  // raw console pins, asynchronous to CLK2
  typedef struct packed {
    logic [arb_pkg::ADDR_W-1:0] addr;
    logic                       rd_n;
    logic                       romsel_n;
    logic                       cpu_clk;
  } snes_pins_t;

  // console bus after sync and filtering
  // levels keep pin polarity, pulses are one CLK2 wide
  typedef struct packed {
    logic [arb_pkg::ADDR_W-1:0] addr;
    logic                       rd_n;
    logic                       romsel_n;
    logic                       cpu_clk;
    logic                       rd_start;
    logic                       cycle_start;
    logic                       cycle_end;
  } snes_evt_t;

  // request from one memory user
  typedef struct packed {
    logic                       rrq;
    logic                       wrq;
    logic                       word;
    logic [arb_pkg::ADDR_W-1:0] addr;
    logic [arb_pkg::DATA_W-1:0] wdata;
  } mem_req_t;

  // handshake and read data back to the user
  typedef struct packed {
    logic                       rdy;
    logic [arb_pkg::DATA_W-1:0] rdata;
  } mem_rsp_t;

  // PSRAM pins, word addressed, active low lanes
  typedef struct packed {
    logic [arb_pkg::ADDR_W-2:0] addr;
    logic                       we_n;
    logic                       bhe_n;
    logic                       ble_n;
    logic [arb_pkg::DATA_W-1:0] dq_out;
    logic                       dq_oe;
  } rom_bus_t;

endpackage

// File: hw/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync #(
  parameter int unsigned SYNC_DEPTH = 6
) (
  input  logic                CLK2,
  input  logic                rst_n,
  input  bus_pkg::snes_pins_t pins,
  output bus_pkg::snes_evt_t  evt
);

  // sample history, bit 0 is the newest sample
  logic [7:0] rd_sr;
  logic [7:0] clk_sr;
  // romsel delayed as far as the address so both line up
  logic [SYNC_DEPTH-1:0] romsel_sr;
  logic [arb_pkg::ADDR_W-1:0] addr_pipe [SYNC_DEPTH];

  logic                       rd_n_q;
  logic                       clk_q;
  logic                       romsel_n_q;
  logic [arb_pkg::ADDR_W-1:0] addr_q;
  logic                       rd_start_q;
  logic                       cycle_start_q;
  logic                       cycle_end_q;

  ////////////////////////////////////////////////////////////////////////////
  // control pins
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      // idle bus, no read, clock low
      rd_sr         <= '1;
      clk_sr        <= '0;
      romsel_sr     <= '1;
      rd_n_q        <= 1'b1;
      clk_q         <= 1'b0;
      romsel_n_q    <= 1'b1;
      rd_start_q    <= 1'b0;
      cycle_start_q <= 1'b0;
      cycle_end_q   <= 1'b0;
    end else begin
      rd_sr     <= {rd_sr[6:0], pins.rd_n};
      clk_sr    <= {clk_sr[6:0], pins.cpu_clk};
      romsel_sr <= {romsel_sr[SYNC_DEPTH-2:0], pins.romsel_n};
      // level only moves on two agreeing samples
      if (rd_sr[2] == rd_sr[1]) begin
        rd_n_q <= rd_sr[1];
      end
      if (clk_sr[2] == clk_sr[1]) begin
        clk_q <= clk_sr[1];
      end
      if (romsel_sr[SYNC_DEPTH-1] == romsel_sr[SYNC_DEPTH-2]) begin
        romsel_n_q <= romsel_sr[SYNC_DEPTH-1];
      end
      // edges from the pattern of adjacent pairs
      // one-sample spikes are masked by the OR / AND
      rd_start_q    <= (rd_sr[6:1] | rd_sr[7:2]) == 6'b111100;
      cycle_start_q <= (clk_sr[6:1] & clk_sr[7:2]) == 6'b000011;
      cycle_end_q   <= (clk_sr[6:1] | clk_sr[7:2]) == 6'b111000;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // address
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= pins.addr;
    for (int i = 1; i < SYNC_DEPTH; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
    // hold the last stable address while the bus settles
    if (addr_pipe[SYNC_DEPTH-1] == addr_pipe[SYNC_DEPTH-2]) begin
      addr_q <= addr_pipe[SYNC_DEPTH-1];
    end
  end

  assign evt = '{
    addr:        addr_q,
    rd_n:        rd_n_q,
    romsel_n:    romsel_n_q,
    cpu_clk:     clk_q,
    rd_start:    rd_start_q,
    cycle_start: cycle_start_q,
    cycle_end:   cycle_end_q
  };

endmodule

// File: hw/snes_alive_timer.sv
`timescale 1ns/1ps

module snes_alive_timer #(
  parameter int unsigned DEAD_TIMEOUT = arb_pkg::DEAD_TIMEOUT_DEF
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic cpu_clk,
  output logic dead,
  output logic reset_strobe
);

  // room for DEAD_TIMEOUT+1, where the count stops
  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);

  logic [CNT_W-1:0] low_cnt;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      low_cnt      <= '0;
      // no console seen yet
      dead         <= 1'b1;
      reset_strobe <= 1'b0;
    end else begin
      reset_strobe <= 1'b0;
      if (cpu_clk) begin
        low_cnt <= '0;
        dead    <= 1'b0;
        // first high clock after a dead phase
        reset_strobe <= dead;
      end else begin
        // stop counting once dead, no wrap
        if (!dead) begin
          low_cnt <= low_cnt + 1'b1;
        end
        // this cycle is low cycle DEAD_TIMEOUT+1
        if (low_cnt >= DEAD_TIMEOUT) begin
          dead <= 1'b1;
        end
      end
    end
  end

  // one strobe per revival
  strobe_single_a: assert property (@(posedge CLK2) disable iff (!rst_n)
    reset_strobe |=> !reset_strobe);

endmodule

// File: hw/mem_req_latch.sv
`timescale 1ns/1ps

module mem_req_latch (
  input  logic                       CLK2,
  input  logic                       rst_n,
  input  bus_pkg::mem_req_t          req,
  input  logic                       grant,
  input  logic                       done,
  input  logic [arb_pkg::DATA_W-1:0] rdata,
  output logic                       rd_pend,
  output logic                       wr_pend,
  output bus_pkg::mem_req_t          held,
  output bus_pkg::mem_rsp_t          rsp
);

  logic                       rdy_q;
  logic [arb_pkg::DATA_W-1:0] rdata_q;

  // handshake
  // read wins if a requester pulses both
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_q   <= 1'b1;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
      rdy_q   <= 1'b0;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
      rdy_q   <= 1'b0;
    end else if (done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_q   <= 1'b1;
    end
  end

  // captured request and returned data
  always_ff @(posedge CLK2) begin
    if (req.rrq || req.wrq) begin
      held <= req;
    end
    // track the PSRAM until the cycle ends, last sample is kept
    if (grant) begin
      rdata_q <= rdata;
    end
  end

  assign rsp = '{rdy: rdy_q, rdata: rdata_q};

  // requester must wait for rdy before the next pulse
  req_while_busy_a: assert property (@(posedge CLK2) disable iff (!rst_n)
    (req.rrq || req.wrq) |-> rdy_q);

endmodule

// File: hw/mem_arbiter_fsm.sv
`timescale 1ns/1ps

module mem_arbiter_fsm #(
  parameter int unsigned ROM_CYCLE_LEN = arb_pkg::ROM_CYCLE_LEN_DEF
) (
  input  logic                CLK2,
  input  logic                rst_n,
  input  bus_pkg::snes_evt_t  evt,
  input  logic                dead,
  // {wr, rd} per source, source 0 in the low pair
  input  logic [5:0]          pend,
  output arb_pkg::arb_state_e state,
  output arb_pkg::req_src_e   src,
  output logic [2:0]          grant,
  output logic [2:0]          done
);

  localparam int CNT_W = $clog2(ROM_CYCLE_LEN + 1);

  logic             free_strobe;
  logic             free_slot;
  logic [CNT_W-1:0] delay_q;

  logic              pick_valid;
  logic              pick_wr;
  arb_pkg::req_src_e pick_src;

  ////////////////////////////////////////////////////////////////////////////
  // free slots
  ////////////////////////////////////////////////////////////////////////////

  // console cycle without romsel leaves the PSRAM idle
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= evt.cycle_start && evt.romsel_n;
    end
  end

  assign free_slot = evt.cycle_end || free_strobe || dead;

  ////////////////////////////////////////////////////////////////////////////
  // priority
  ////////////////////////////////////////////////////////////////////////////

  // gsu rom, gsu ram, mcu; read before write within a source
  always_comb begin
    pick_valid = 1'b0;
    pick_wr    = 1'b0;
    pick_src   = arb_pkg::src_gsu_rom;
    // lowest priority first, later hits override
    for (int i = 2; i >= 0; i--) begin
      if (pend[2*i] || pend[2*i+1]) begin
        pick_valid = 1'b1;
        pick_wr    = !pend[2*i];
        pick_src   = arb_pkg::req_src_e'(2'(i));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state   <= arb_pkg::idle;
      src     <= arb_pkg::src_gsu_rom;
      delay_q <= '0;
    end else if (dead && evt.cpu_clk) begin
      // console revived, abort
      // pending flag stays set so the access runs again
      state <= arb_pkg::idle;
    end else begin
      case (state)
        arb_pkg::idle: begin
          if (free_slot && pick_valid) begin
            state   <= pick_wr ? arb_pkg::wr_addr : arb_pkg::rd_addr;
            src     <= pick_src;
            delay_q <= CNT_W'(ROM_CYCLE_LEN);
          end
        end
        arb_pkg::rd_addr, arb_pkg::wr_addr: begin
          // ROM_CYCLE_LEN+1 cycles on the pins
          delay_q <= delay_q - 1'b1;
          if (delay_q == '0) begin
            state <= arb_pkg::done;
          end
        end
        default: begin
          state <= arb_pkg::idle;
        end
      endcase
    end
  end

  // per-source decode of the access in flight
  always_comb begin
    grant = '0;
    done  = '0;
    if (state == arb_pkg::rd_addr || state == arb_pkg::wr_addr) begin
      grant[src] = 1'b1;
    end
    if (state == arb_pkg::done) begin
      done[src] = 1'b1;
    end
  end

  grant_onehot_a: assert property (@(posedge CLK2) disable iff (!rst_n)
    $onehot0(grant));

endmodule

// File: hw/rom_port_mux.sv
`timescale 1ns/1ps

module rom_port_mux (
  input  arb_pkg::arb_state_e        state,
  input  arb_pkg::req_src_e          src,
  input  bus_pkg::snes_evt_t         evt,
  input  bus_pkg::mem_req_t          mcu_held,
  input  bus_pkg::mem_req_t          gsu_rom_held,
  input  bus_pkg::mem_req_t          gsu_ram_held,
  input  logic [arb_pkg::DATA_W-1:0] rom_dq_in,
  output bus_pkg::rom_bus_t          rom,
  output logic [arb_pkg::DATA_W-1:0] rdata,
  output logic [7:0]                 snes_dout,
  output logic                       snes_dout_oe
);

  bus_pkg::mem_req_t          sel;
  logic                       active;
  logic                       write;
  logic                       word;
  logic                       a0;
  logic [arb_pkg::ADDR_W-1:0] addr;
  logic [7:0]                 this_byte;
  logic [7:0]                 other_byte;

  // captured request of the current owner
  always_comb begin
    case (src)
      arb_pkg::src_gsu_rom: sel = gsu_rom_held;
      arb_pkg::src_gsu_ram: sel = gsu_ram_held;
      default:              sel = mcu_held;
    endcase
  end

  // console owns the pins whenever the arbiter is idle
  assign active = state != arb_pkg::idle;
  assign write  = state == arb_pkg::wr_addr;
  assign addr   = active ? sel.addr : evt.addr;
  assign a0     = addr[0];
  assign word   = active && sel.word;

  // even byte on the upper lane, odd byte on the lower lane
  assign this_byte  = a0 ? rom_dq_in[7:0] : rom_dq_in[15:8];
  assign other_byte = a0 ? rom_dq_in[15:8] : rom_dq_in[7:0];

  // byte at addr in [7:0], its partner addr^1 in [15:8]
  assign rdata = {word ? other_byte : 8'h00, this_byte};

  assign rom = '{
    addr:   addr[arb_pkg::ADDR_W-1:1],
    we_n:   !write,
    // word access opens both lanes
    bhe_n:  a0 && !word,
    ble_n:  !a0 && !word,
    // write data in read order, wdata[7:0] lands on addr
    dq_out: a0 ? sel.wdata : {sel.wdata[7:0], sel.wdata[15:8]},
    dq_oe:  write
  };

  // console ROM read
  assign snes_dout    = this_byte;
  assign snes_dout_oe = !evt.rd_n && !evt.romsel_n;

  always_comb begin
    dq_vs_console_a: assert (!(write && snes_dout_oe))
      else $error("PSRAM write during console ROM read");
  end

endmodule

// File: hw/mem_arbiter_top.sv
`timescale 1ns/1ps

module mem_arbiter_top #(
  parameter int unsigned ROM_CYCLE_LEN = arb_pkg::ROM_CYCLE_LEN_DEF,
  parameter int unsigned DEAD_TIMEOUT  = arb_pkg::DEAD_TIMEOUT_DEF,
  parameter int unsigned SYNC_DEPTH    = 6
) (
  input  logic                       CLK2,
  input  logic                       rst_n,
  input  bus_pkg::snes_pins_t        snes,
  input  bus_pkg::mem_req_t          mcu_req,
  input  bus_pkg::mem_req_t          gsu_rom_req,
  input  bus_pkg::mem_req_t          gsu_ram_req,
  input  logic [arb_pkg::DATA_W-1:0] rom_dq_in,
  output bus_pkg::mem_rsp_t          mcu_rsp,
  output bus_pkg::mem_rsp_t          gsu_rom_rsp,
  output bus_pkg::mem_rsp_t          gsu_ram_rsp,
  output bus_pkg::rom_bus_t          rom,
  output logic [7:0]                 snes_dout,
  output logic                       snes_dout_oe,
  output logic                       snes_reset_strobe
);

  bus_pkg::snes_evt_t         evt;
  logic                       dead;
  // pairs {wr, rd} indexed by req_src_e
  logic [5:0]                 pend;
  arb_pkg::arb_state_e        state;
  arb_pkg::req_src_e          src;
  logic [2:0]                 grant;
  logic [2:0]                 done;
  bus_pkg::mem_req_t          mcu_held;
  bus_pkg::mem_req_t          gsu_rom_held;
  bus_pkg::mem_req_t          gsu_ram_held;
  logic [arb_pkg::DATA_W-1:0] rdata;

  ////////////////////////////////////////////////////////////////////////////
  // console side
  ////////////////////////////////////////////////////////////////////////////

  snes_bus_sync #(
    .SYNC_DEPTH(SYNC_DEPTH)
  ) snes_bus_sync_i (
    .CLK2 (CLK2),
    .rst_n(rst_n),
    .pins (snes),
    .evt  (evt)
  );

  snes_alive_timer #(
    .DEAD_TIMEOUT(DEAD_TIMEOUT)
  ) snes_alive_timer_i (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .cpu_clk     (evt.cpu_clk),
    .dead        (dead),
    .reset_strobe(snes_reset_strobe)
  );

  ////////////////////////////////////////////////////////////////////////////
  // requesters and arbitration
  ////////////////////////////////////////////////////////////////////////////

  mem_req_latch gsu_rom_latch_i (
    .CLK2   (CLK2),
    .rst_n  (rst_n),
    .req    (gsu_rom_req),
    .grant  (grant[arb_pkg::src_gsu_rom]),
    .done   (done[arb_pkg::src_gsu_rom]),
    .rdata  (rdata),
    .rd_pend(pend[0]),
    .wr_pend(pend[1]),
    .held   (gsu_rom_held),
    .rsp    (gsu_rom_rsp)
  );

  mem_req_latch gsu_ram_latch_i (
    .CLK2   (CLK2),
    .rst_n  (rst_n),
    .req    (gsu_ram_req),
    .grant  (grant[arb_pkg::src_gsu_ram]),
    .done   (done[arb_pkg::src_gsu_ram]),
    .rdata  (rdata),
    .rd_pend(pend[2]),
    .wr_pend(pend[3]),
    .held   (gsu_ram_held),
    .rsp    (gsu_ram_rsp)
  );

  mem_req_latch mcu_latch_i (
    .CLK2   (CLK2),
    .rst_n  (rst_n),
    .req    (mcu_req),
    .grant  (grant[arb_pkg::src_mcu]),
    .done   (done[arb_pkg::src_mcu]),
    .rdata  (rdata),
    .rd_pend(pend[4]),
    .wr_pend(pend[5]),
    .held   (mcu_held),
    .rsp    (mcu_rsp)
  );

  mem_arbiter_fsm #(
    .ROM_CYCLE_LEN(ROM_CYCLE_LEN)
  ) mem_arbiter_fsm_i (
    .CLK2 (CLK2),
    .rst_n(rst_n),
    .evt  (evt),
    .dead (dead),
    .pend (pend),
    .state(state),
    .src  (src),
    .grant(grant),
    .done (done)
  );

  // PSRAM pins
  rom_port_mux rom_port_mux_i (
    .state       (state),
    .src         (src),
    .evt         (evt),
    .mcu_held    (mcu_held),
    .gsu_rom_held(gsu_rom_held),
    .gsu_ram_held(gsu_ram_held),
    .rom_dq_in   (rom_dq_in),
    .rom         (rom),
    .rdata       (rdata),
    .snes_dout   (snes_dout),
    .snes_dout_oe(snes_dout_oe)
  );

endmodule

// File: dv/tb_mem_arbiter.sv
`timescale 1ns/1ps

module tb_mem_arbiter;

  logic                CLK2 = 1'b0;
  logic                rst_n;
  // console pins start idle, clock low, no read
  bus_pkg::snes_pins_t snes = '{addr: 24'h00_8000, rd_n: 1'b1, romsel_n: 1'b1, cpu_clk: 1'b0};
  bus_pkg::mem_req_t   mcu_req;
  bus_pkg::mem_req_t   gsu_rom_req;
  bus_pkg::mem_req_t   gsu_ram_req;
  logic [15:0]         rom_dq_in;
  bus_pkg::mem_rsp_t   mcu_rsp;
  bus_pkg::mem_rsp_t   gsu_rom_rsp;
  bus_pkg::mem_rsp_t   gsu_ram_rsp;
  bus_pkg::rom_bus_t   rom;
  logic [7:0]          snes_dout;
  logic                snes_dout_oe;
  logic                snes_reset_strobe;

  // PSRAM image, byte addressed, low 16 address bits only
  logic [7:0] mem [65536];
  logic [7:0] console_byte;
  integer     seed;
  logic       console_run = 1'b0;
  int         console_phase = 0;
  int         strobe_cnt = 0;
  int         oe_cycles = 0;

  mem_arbiter_top #(
    .ROM_CYCLE_LEN(6),
    .DEAD_TIMEOUT (200)
  ) mem_arbiter_top_i (
    .CLK2             (CLK2),
    .rst_n            (rst_n),
    .snes             (snes),
    .mcu_req          (mcu_req),
    .gsu_rom_req      (gsu_rom_req),
    .gsu_ram_req      (gsu_ram_req),
    .rom_dq_in        (rom_dq_in),
    .mcu_rsp          (mcu_rsp),
    .gsu_rom_rsp      (gsu_rom_rsp),
    .gsu_ram_rsp      (gsu_ram_rsp),
    .rom              (rom),
    .snes_dout        (snes_dout),
    .snes_dout_oe     (snes_dout_oe),
    .snes_reset_strobe(snes_reset_strobe)
  );

  always #5 CLK2 = ~CLK2;

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model and console bus
  ////////////////////////////////////////////////////////////////////////////

  // even byte on upper lane, closed lane reads zero
  assign rom_dq_in = {rom.bhe_n ? 8'h00 : mem[{rom.addr[14:0], 1'b0}],
                      rom.ble_n ? 8'h00 : mem[{rom.addr[14:0], 1'b1}]};

  always @(posedge CLK2) begin
    if (!rom.we_n) begin
      if (!rom.bhe_n) begin
        mem[{rom.addr[14:0], 1'b0}] <= rom.dq_out[15:8];
      end
      if (!rom.ble_n) begin
        mem[{rom.addr[14:0], 1'b1}] <= rom.dq_out[7:0];
      end
    end
  end

  // 24 CLK2 per console cycle
  // clock low in phases 0..11, high in 12..23, rd_n low in 18..23
  always @(negedge CLK2) begin
    if (console_run) begin
      snes.cpu_clk  <= console_phase >= 12;
      snes.rd_n     <= console_phase < 18;
      snes.romsel_n <= 1'b0;
      // new address on the rising console clock
      if (console_phase == 12) begin
        snes.addr <= snes.addr + 24'd3;
      end
      console_phase <= (console_phase == 23) ? 0 : console_phase + 1;
    end else begin
      snes.cpu_clk  <= 1'b0;
      snes.rd_n     <= 1'b1;
      snes.romsel_n <= 1'b1;
      console_phase <= 0;
    end
  end

  assign console_byte = mem[snes.addr[15:0]];

  always @(posedge CLK2) begin
    if (snes_reset_strobe) begin
      strobe_cnt <= strobe_cnt + 1;
    end
    if (snes_dout_oe) begin
      oe_cycles <= oe_cycles + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    fail_run($sformatf("Error at %0t ns: %s", $time, msg));
  endtask

  // console read data straight from the model
  console_data_a: assert property (@(posedge CLK2) disable iff (!rst_n)
    snes_dout_oe |-> snes_dout == console_byte)
    else report_mismatch($sformatf("console read at %h gave %h, model holds %h",
                                   snes.addr, snes_dout, console_byte));

  function automatic bus_pkg::mem_req_t make_req(input logic wr, input logic word,
                                                 input logic [23:0] addr,
                                                 input logic [15:0] wdata);
    bus_pkg::mem_req_t r;
    r       = '0;
    r.rrq   = !wr;
    r.wrq   = wr;
    r.word  = word;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic logic rdy_of(input arb_pkg::req_src_e who);
    case (who)
      arb_pkg::src_gsu_rom: return gsu_rom_rsp.rdy;
      arb_pkg::src_gsu_ram: return gsu_ram_rsp.rdy;
      default:              return mcu_rsp.rdy;
    endcase
  endfunction

  // one-cycle pulse on all three ports, on the falling edge
  task automatic drive_requests(input bus_pkg::mem_req_t rom_r, input bus_pkg::mem_req_t ram_r,
                                input bus_pkg::mem_req_t mcu_r);
    @(negedge CLK2);
    gsu_rom_req = rom_r;
    gsu_ram_req = ram_r;
    mcu_req     = mcu_r;
    @(negedge CLK2);
    gsu_rom_req = '0;
    gsu_ram_req = '0;
    mcu_req     = '0;
  endtask

  task automatic wait_rdy(input arb_pkg::req_src_e who, input int limit);
    int n;
    n = 0;
    while (!rdy_of(who)) begin
      if (n >= limit) begin
        fail_run($sformatf("%s rdy did not come back within %0d cycles", who.name(), limit));
      end else begin
        @(negedge CLK2);
        n++;
      end
    end
  endtask

  task automatic check_mcu_read(input logic [23:0] a);
    logic [7:0] exp;
    exp = mem[a[15:0]];
    drive_requests('0, '0, make_req(1'b0, 1'b0, a, 16'h0000));
    wait_rdy(arb_pkg::src_mcu, 200);
    mcu_read_a: assert (mcu_rsp.rdata[7:0] == exp)
      else report_mismatch($sformatf("mcu read at %h gave %h, expected %h",
                                     a, mcu_rsp.rdata[7:0], exp));
  endtask

  // upper wdata byte is junk, the MCU only drives [7:0]
  task automatic check_mcu_write(input logic [23:0] a, input logic [7:0] d);
    logic [7:0] partner;
    partner = mem[a[15:0] ^ 16'h0001];
    drive_requests('0, '0, make_req(1'b1, 1'b0, a, {8'hc3, d}));
    wait_rdy(arb_pkg::src_mcu, 200);
    mcu_write_a: assert (mem[a[15:0]] == d && mem[a[15:0] ^ 16'h0001] == partner)
      else report_mismatch($sformatf("mcu write of %h at %h left %h, partner %h",
                                     d, a, mem[a[15:0]], mem[a[15:0] ^ 16'h0001]));
  endtask

  // word read at an even address, byte at a in the low half
  task automatic check_word_read(input arb_pkg::req_src_e who, input logic [23:0] a);
    bus_pkg::mem_req_t r;
    logic [15:0]       exp;
    logic [15:0]       got;
    exp = {mem[a[15:0] + 16'd1], mem[a[15:0]]};
    r   = make_req(1'b0, 1'b1, a, 16'h0000);
    if (who == arb_pkg::src_gsu_rom) begin
      drive_requests(r, '0, '0);
    end else begin
      drive_requests('0, r, '0);
    end
    wait_rdy(who, 200);
    got = (who == arb_pkg::src_gsu_rom) ? gsu_rom_rsp.rdata : gsu_ram_rsp.rdata;
    word_read_a: assert (got == exp)
      else report_mismatch($sformatf("%s word read at %h gave %h, expected %h",
                                     who.name(), a, got, exp));
  endtask

  task automatic check_ram_word_write(input logic [23:0] a, input logic [15:0] d);
    drive_requests('0, make_req(1'b1, 1'b1, a, d), '0);
    wait_rdy(arb_pkg::src_gsu_ram, 200);
    word_write_a: assert (mem[a[15:0]] == d[7:0] && mem[a[15:0] + 16'd1] == d[15:8])
      else report_mismatch($sformatf("gsu ram word write of %h at %h left %h %h",
                                     d, a, mem[a[15:0] + 16'd1], mem[a[15:0]]));
  endtask

  // all three in one cycle, note when each rdy returns
  task automatic check_order();
    int rom_t;
    int ram_t;
    int mcu_t;
    int n;
    rom_t = -1;
    ram_t = -1;
    mcu_t = -1;
    n     = 0;
    drive_requests(make_req(1'b0, 1'b1, 24'h40_0010, 16'h0000),
                   make_req(1'b0, 1'b1, 24'h70_0010, 16'h0000),
                   make_req(1'b0, 1'b0, 24'h00_0011, 16'h0000));
    while (rom_t < 0 || ram_t < 0 || mcu_t < 0) begin
      if (n >= 100) begin
        fail_run("concurrent requests did not all complete within 100 cycles");
      end else begin
        if (rom_t < 0 && gsu_rom_rsp.rdy) rom_t = n;
        if (ram_t < 0 && gsu_ram_rsp.rdy) ram_t = n;
        if (mcu_t < 0 && mcu_rsp.rdy) mcu_t = n;
        @(negedge CLK2);
        n++;
      end
    end
    order_a: assert (rom_t < ram_t && ram_t < mcu_t)
      else report_mismatch($sformatf("rdy order rom %0d ram %0d mcu %0d", rom_t, ram_t, mcu_t));
  endtask

  task automatic wait_strobe(input int limit);
    int n;
    n = 0;
    while (!snes_reset_strobe) begin
      if (n >= limit) begin
        fail_run($sformatf("no console reset strobe within %0d cycles of restart", limit));
      end else begin
        @(negedge CLK2);
        n++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    int          strobes_before;
    seed        = 83315;
    rst_n       = 1'b0;
    mcu_req     = '0;
    gsu_rom_req = '0;
    gsu_ram_req = '0;
    for (int i = 0; i < 65536; i++) begin
      rnd    = $random(seed);
      mem[i] = rnd[7:0];
    end
    repeat (3) @(negedge CLK2);
    rst_n = 1'b1;
    @(negedge CLK2);
    reset_rdy_a: assert (gsu_rom_rsp.rdy && gsu_ram_rsp.rdy && mcu_rsp.rdy)
      else report_mismatch("a rdy is low after reset");
    reset_pins_a: assert (rom.we_n && !rom.dq_oe && !snes_dout_oe)
      else report_mismatch("PSRAM or console drivers active after reset");

    // console still dead, every cycle is a slot
    check_mcu_read(24'h00_1235);
    check_mcu_read(24'h00_1236);
    check_mcu_write(24'h00_2001, 8'h5a);
    check_mcu_write(24'h00_2002, 8'ha5);
    check_mcu_read(24'h00_2001);
    check_word_read(arb_pkg::src_gsu_rom, 24'h40_3000);
    check_word_read(arb_pkg::src_gsu_ram, 24'h70_0120);
    check_ram_word_write(24'h70_0124, 16'hbeef);
    check_word_read(arb_pkg::src_gsu_ram, 24'h70_0124);
    check_order();

    // console running, mcu only gets the gaps
    console_run <= 1'b1;
    repeat (48) @(negedge CLK2);
    check_mcu_read(24'h00_4567);
    check_mcu_read(24'h00_4568);
    repeat (96) @(negedge CLK2);
    oe_seen_a: assert (oe_cycles > 0)
      else fail_run("console ROM reads never enabled snes_dout");

    // stop past the dead threshold, then revive
    console_run <= 1'b0;
    repeat (300) @(negedge CLK2);
    strobes_before = strobe_cnt;
    console_run <= 1'b1;
    wait_strobe(100);
    repeat (72) @(negedge CLK2);
    console_run <= 1'b0;
    repeat (10) @(negedge CLK2);
    strobe_once_a: assert (strobe_cnt - strobes_before == 1)
      else report_mismatch($sformatf("%0d reset strobes after revival",
                                     strobe_cnt - strobes_before));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: mem_arbiter.f
hw/arb_pkg.sv
hw/bus_pkg.sv
hw/snes_bus_sync.sv
hw/snes_alive_timer.sv
hw/mem_req_latch.sv
hw/mem_arbiter_fsm.sv
hw/rom_port_mux.sv
hw/mem_arbiter_top.sv
dv/tb_mem_arbiter.sv

// File: Makefile
TOP := tb_mem_arbiter

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mem_arbiter.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
